//--- Makefile
SIM      = verilator
SIMFLAGS = --binary --timing --assert
TOP      = tb_look_ahead_router
FILELIST = project.f
OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)
LOG      = sim.log
CASES    = lookahead_cases.txt
SRCS     = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN) $(CASES)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^TESTS PASSED$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- hop_if.sv
// Next-hop view of a registered request, as seen from the neighbor router.
// Driven by the hop predictor; the route computation reads the addresses
// and the port mask remover reads the predicted entry port.

`timescale 1ns/1ps

interface hop_if;
    import lookahead_pkg::*;

    coord_t       next_x;     // predicted neighbor address
    coord_t       next_y;
    coord_t       dest_x;     // registered destination
    coord_t       dest_y;
    port_onehot_t entry_port; // port the packet enters the neighbor by

    modport src (
        output next_x, next_y, dest_x, dest_y, entry_port
    );

    modport route (
        input next_x, next_y, dest_x, dest_y
    );

    modport strip (
        input entry_port
    );

endinterface

//--- hop_predictor.sv
// Request register and next-hop prediction for one input port.
// Samples the destination and the chosen output port every cycle, puts the
// switch location back into the port mask and predicts which neighbor the
// packet reaches and by which port it enters there.
// Outputs are combinational from the registered request.

`timescale 1ns/1ps

module hop_predictor #(
    parameter int NX     = 4,
    parameter int NY     = 4,
    parameter int SW_LOC = 0
) (
    input  logic                      clk,
    input  logic                      reset,
    input  lookahead_pkg::coord_t     current_x,
    input  lookahead_pkg::coord_t     current_y,
    input  lookahead_pkg::coord_t     dest_x,
    input  lookahead_pkg::coord_t     dest_y,
    input  lookahead_pkg::port_mask_t destport,
    hop_if.src                        hop
);
    import lookahead_pkg::*;

    localparam coord_t LAST_X = coord_t'(NX - 1);
    localparam coord_t LAST_Y = coord_t'(NY - 1);

    coord_t       dest_x_q;
    coord_t       dest_y_q;
    port_mask_t   destport_q;
    port_onehot_t port_oh;     // destport with the switch location restored
    port_onehot_t entry_oh;
    coord_t       next_x;
    coord_t       next_y;

    // one request per cycle, no back-pressure
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dest_x_q   <= '0;
            dest_y_q   <= '0;
            destport_q <= '0; // reads as no port
        end else begin
            dest_x_q   <= dest_x;
            dest_y_q   <= dest_y;
            destport_q <= destport;
        end
    end

    // the input port never routes back to itself, so its bit is zero
    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_sw_loc
        if (i > SW_LOC) begin : g_above
            assign port_oh[i] = destport_q[i-1];
        end else if (i == SW_LOC) begin : g_self
            assign port_oh[i] = 1'b0;
        end else begin : g_below
            assign port_oh[i] = destport_q[i];
        end
    end

    // y grows toward south; a mesh edge has no neighbor beyond it
    always_comb begin
        next_x = current_x;
        next_y = current_y;
        if (port_oh[EAST_PORT]) begin
            if (current_x != LAST_X) next_x = current_x + coord_t'(1);
        end else if (port_oh[NORTH_PORT]) begin
            if (current_y != '0) next_y = current_y - coord_t'(1);
        end else if (port_oh[WEST_PORT]) begin
            if (current_x != '0) next_x = current_x - coord_t'(1);
        end else if (port_oh[SOUTH_PORT]) begin
            if (current_y != LAST_Y) next_y = current_y + coord_t'(1);
        end
    end

    // leaving east means arriving from the west, and so on
    assign entry_oh[LOCAL_PORT] = port_oh[LOCAL_PORT];
    assign entry_oh[EAST_PORT]  = port_oh[WEST_PORT];
    assign entry_oh[WEST_PORT]  = port_oh[EAST_PORT];
    assign entry_oh[NORTH_PORT] = port_oh[SOUTH_PORT];
    assign entry_oh[SOUTH_PORT] = port_oh[NORTH_PORT];

    assign hop.next_x     = next_x;
    assign hop.next_y     = next_y;
    assign hop.dest_x     = dest_x_q;
    assign hop.dest_y     = dest_y_q;
    assign hop.entry_port = entry_oh;

endmodule

//--- look_ahead_router.sv
// Look-ahead route stage for one input port of a 2D mesh router.
// A request (destination and chosen output port) is registered on the
// rising clock edge; one cycle later lkdestport gives the port the next
// router will use, with its own entry port left out. current_x and
// current_y are the static address of this router.

`timescale 1ns/1ps

module look_ahead_router #(
    parameter int NX     = 4,
    parameter int NY     = 4,
    parameter int SW_LOC = 0 // input port served by this stage
) (
    input  logic                      clk,
    input  logic                      reset,
    input  lookahead_pkg::coord_t     current_x,
    input  lookahead_pkg::coord_t     current_y,
    input  lookahead_pkg::coord_t     dest_x,
    input  lookahead_pkg::coord_t     dest_y,
    input  lookahead_pkg::port_mask_t destport,
    output lookahead_pkg::port_mask_t lkdestport
);
    import lookahead_pkg::*;

    hop_if        hop ();
    port_onehot_t route_port; // neighbor's XY decision

    hop_predictor #(
        .NX     (NX),
        .NY     (NY),
        .SW_LOC (SW_LOC)
    ) u_hop_predictor (
        .clk       (clk),
        .reset     (reset),
        .current_x (current_x),
        .current_y (current_y),
        .dest_x    (dest_x),
        .dest_y    (dest_y),
        .destport  (destport),
        .hop       (hop.src)
    );

    xy_route_compute #(
        .NX (NX),
        .NY (NY)
    ) u_xy_route_compute (
        .hop        (hop.route),
        .route_port (route_port)
    );

    port_mask_remover u_port_mask_remover (
        .hop        (hop.strip),
        .route_port (route_port),
        .lkdestport (lkdestport)
    );

endmodule

//--- look_ahead_router_assert.sv
// Concurrent checks on the ports of the look-ahead route stage.
// Bound to every look_ahead_router instance; all checks are idle while
// reset is high. fail_count tallies the failed checks.

`timescale 1ns/1ps

module look_ahead_router_assert (
    input logic                      clk,
    input logic                      reset,
    input lookahead_pkg::port_mask_t destport,
    input lookahead_pkg::port_mask_t lkdestport
);

    int fail_count = 0;

    // next router gets a single port or none
    property p_lk_at_most_one;
        @(posedge clk) disable iff (reset) $onehot0(lkdestport);
    endproperty

    property p_lk_known;
        @(posedge clk) disable iff (reset) !$isunknown(lkdestport);
    endproperty

    // every request names exactly one output port
    property p_destport_onehot;
        @(posedge clk) disable iff (reset) $onehot(destport);
    endproperty

    a_lk_at_most_one: assert property (p_lk_at_most_one) else begin
        fail_count++;
        $error("lkdestport has more than one bit set: %b", lkdestport);
    end

    a_lk_known: assert property (p_lk_known) else begin
        fail_count++;
        $error("lkdestport carries unknown bits: %b", lkdestport);
    end

    a_destport_onehot: assert property (p_destport_onehot) else begin
        fail_count++;
        $error("destport is not one-hot: %b", destport);
    end

endmodule

bind look_ahead_router look_ahead_router_assert u_assert (
    .clk        (clk),
    .reset      (reset),
    .destport   (destport),
    .lkdestport (lkdestport)
);

//--- lookahead_cases.txt
# columns (hex): current_x current_y dest_x dest_y destport expected_lkdestport
# destport bits for input port 0: 1 east, 2 north, 4 west, 8 south
# straight east, neighbor keeps going east
0 0 3 0 1 2
0 1 2 1 1 2
1 2 3 2 1 2
0 3 3 1 1 2
1 0 3 3 1 2
0 2 2 0 1 2
# turn at the neighbor after east or west
0 0 1 2 1 8
1 3 2 0 1 4
2 1 3 0 1 4
2 1 3 3 1 8
0 2 1 1 1 4
1 1 2 3 1 8
3 0 2 3 4 8
3 3 2 0 4 2
2 2 1 1 4 2
1 1 0 2 4 8
# neighbor is the destination
1 1 2 1 1 1
2 2 1 2 4 1
1 2 1 1 2 1
3 0 3 1 8 1
0 0 1 0 1 1
3 3 3 2 2 1
0 3 0 2 2 1
2 0 2 1 8 1
# straight west
3 1 0 1 4 4
3 0 0 3 4 4
2 3 0 3 4 4
3 2 1 2 4 4
# straight north
1 3 1 0 2 4
2 2 2 0 2 4
0 3 0 1 2 4
3 3 3 0 2 4
# straight south
1 0 1 3 8 8
2 1 2 3 8 8
0 0 0 2 8 8
3 1 3 3 8 8
# more from edge routers
0 1 3 1 1 2
2 3 3 3 1 1
1 1 3 0 1 2
3 3 1 0 4 4
1 0 0 0 4 1
2 0 0 0 4 4
# mixed back-to-back requests
1 1 3 1 1 2
2 2 2 0 2 4
1 2 0 2 4 1
2 1 2 3 8 8
0 0 1 3 1 8
3 2 2 0 4 2
1 3 1 2 2 1
2 0 3 3 1 8

//--- lookahead_pkg.sv
// Shared definitions for the look-ahead route stage of a 2D mesh router.
// Holds the coordinate width, the port numbering of the five-port router
// and the vector types for one-hot port selections and 4-bit port masks.
// Modules import it by wildcard inside their bodies and use scoped names
// in their port lists.

package lookahead_pkg;

    // mesh coordinates, up to 16 routers per axis
    localparam int COORD_W = 4;

    typedef logic [COORD_W-1:0] coord_t; // one x or y router address

    // router ports
    localparam int NUM_PORTS = 5;

    // bit positions in the one-hot port vector
    localparam int LOCAL_PORT = 0;
    localparam int EAST_PORT  = 1;
    localparam int NORTH_PORT = 2;
    localparam int WEST_PORT  = 3;
    localparam int SOUTH_PORT = 4;

    // one-hot over all five ports
    typedef logic [NUM_PORTS-1:0] port_onehot_t;

    // Port selection with one port removed, either the switch location of
    // the input port or the predicted entry port at the next router. The
    // remaining ports keep their relative order, so a port above the
    // removed one moves down by one bit.
    typedef logic [NUM_PORTS-2:0] port_mask_t;

endpackage

//--- port_mask_remover.sv
// Turns the neighbor's one-hot route into the 4-bit look-ahead port mask.
// The port the packet enters the neighbor by is dropped from the vector,
// so routes above it move down one bit and routes below it keep their bit.
// Purely combinational.

`timescale 1ns/1ps

module port_mask_remover (
    hop_if.strip                        hop,
    input  lookahead_pkg::port_onehot_t route_port,
    output lookahead_pkg::port_mask_t   lkdestport
);
    import lookahead_pkg::*;

    typedef logic [2:0] port_idx_t; // index 0 to 4

    port_idx_t  route_idx;
    port_idx_t  entry_idx;
    logic [1:0] mask_idx;  // bit position in the 4-bit mask

    // one-hot to index, zero when no bit is set
    function automatic port_idx_t onehot_to_idx(input port_onehot_t oh);
        port_idx_t idx;
        idx = '0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (oh[i]) idx = idx | port_idx_t'(i);
        end
        return idx;
    endfunction

    assign route_idx = onehot_to_idx(route_port);
    assign entry_idx = onehot_to_idx(hop.entry_port);

    // Below the entry port the index stands. At or above it, step down by
    // one; route index 4 wraps its low bits to 0 and lands on 3 as needed.
    assign mask_idx = (entry_idx > route_idx) ? route_idx[1:0]
                                              : route_idx[1:0] - 2'd1;

    assign lkdestport = port_mask_t'(1) << mask_idx;

endmodule

//--- project.f
lookahead_pkg.sv
hop_if.sv
hop_predictor.sv
xy_route_compute.sv
port_mask_remover.sv
look_ahead_router.sv
look_ahead_router_assert.sv
tb_look_ahead_router.sv

//--- tb_look_ahead_router.sv
// Testbench for the look-ahead route stage of a 4x4 mesh router.
// Reads requests and expected look-ahead masks from lookahead_cases.txt,
// drives one request per cycle on the falling edge and checks lkdestport
// one cycle later. Serves input port 0, so destport bits are east, north,
// west and south from bit 0 up.

`timescale 1ns/1ps

module tb_look_ahead_router;
    import lookahead_pkg::*;

    localparam int    CLK_PERIOD = 8;
    localparam int    NX         = 4;
    localparam int    NY         = 4;
    localparam int    SW_LOC     = 0;
    localparam string CASES_FILE = "lookahead_cases.txt";

    logic       clk;
    logic       reset;
    coord_t     current_x;
    coord_t     current_y;
    coord_t     dest_x;
    coord_t     dest_y;
    port_mask_t destport;
    port_mask_t lkdestport;

    // one entry per test vector
    coord_t     cx_q[$];
    coord_t     cy_q[$];
    coord_t     dx_q[$];
    coord_t     dy_q[$];
    port_mask_t port_q[$];
    port_mask_t exp_q[$];

    int   num_cases;
    int   errors;
    int   checks;
    int   assert_fails;
    logic cases_loaded; // watchdog waits for this

    look_ahead_router #(
        .NX     (NX),
        .NY     (NY),
        .SW_LOC (SW_LOC)
    ) dut (
        .clk        (clk),
        .reset      (reset),
        .current_x  (current_x),
        .current_y  (current_y),
        .dest_x     (dest_x),
        .dest_y     (dest_y),
        .destport   (destport),
        .lkdestport (lkdestport)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // true for a line with nothing but white space
    function automatic bit is_blank(string s);
        byte c;
        for (int k = 0; k < s.len(); k++) begin
            c = s.getc(k);
            if (c != 8'h20 && c != 8'h09 && c != 8'h0a && c != 8'h0d) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic load_cases();
        int    fd;
        int    code;
        int    line_no;
        int    v_cx;
        int    v_cy;
        int    v_dx;
        int    v_dy;
        int    v_port;
        int    v_exp;
        string line;
        fd = $fopen(CASES_FILE, "r");
        if (fd == 0) begin
            $display("cannot open %s, no test vectors to run", CASES_FILE);
            errors++;
            return;
        end
        line_no = 0;
        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            line_no++;
            if (code > 0 && line.getc(0) != 8'h23 && !is_blank(line)) begin
                code = $sscanf(line, "%h %h %h %h %h %h",
                               v_cx, v_cy, v_dx, v_dy, v_port, v_exp);
                if (code == 6 && v_cx < 16 && v_cy < 16 && v_dx < 16
                        && v_dy < 16 && v_port < 16 && v_exp < 16) begin
                    cx_q.push_back(coord_t'(v_cx));
                    cy_q.push_back(coord_t'(v_cy));
                    dx_q.push_back(coord_t'(v_dx));
                    dy_q.push_back(coord_t'(v_dy));
                    port_q.push_back(port_mask_t'(v_port));
                    exp_q.push_back(port_mask_t'(v_exp));
                end else begin
                    $display("line %0d of %s is malformed and was skipped",
                             line_no, CASES_FILE);
                    errors++;
                end
            end
        end
        $fclose(fd);
        if (cx_q.size() == 0) begin
            $display("no test vectors found in %s", CASES_FILE);
            errors++;
        end
    endtask

    task automatic drive_case(input int i);
        current_x = cx_q[i];
        current_y = cy_q[i];
        dest_x    = dx_q[i];
        dest_y    = dy_q[i];
        destport  = port_q[i];
    endtask

    // output of request i, one clock after it was sampled
    task automatic check_case(input int i);
        checks++;
        if (lkdestport !== exp_q[i]) begin
            $display("FAILED at %0t: lkdestport = %b, expected %b (case %0d)",
                     $time, lkdestport, exp_q[i], i);
            errors++;
        end
    endtask

    initial begin
        reset        = 1'b1;
        current_x    = '0;
        current_y    = '0;
        dest_x       = '0;
        dest_y       = '0;
        destport     = '0;
        errors       = 0;
        checks       = 0;
        assert_fails = 0;
        num_cases    = 0;
        cases_loaded = 1'b0;

        load_cases();
        num_cases    = cx_q.size();
        cases_loaded = 1'b1;

        repeat (3) @(posedge clk);
        @(negedge clk);
        if (num_cases > 0) begin
            reset = 1'b0;
            drive_case(0); // first request lands on the next rising edge
            for (int i = 1; i < num_cases; i++) begin
                @(negedge clk);
                check_case(i - 1); // before current_x/y move on
                drive_case(i);
            end
            @(negedge clk);
            check_case(num_cases - 1);
        end

        assert_fails = dut.u_assert.fail_count;
        errors       = errors + assert_fails;
        $display("%0d cases, %0d checks, %0d assertion failures, %0d errors",
                 num_cases, checks, assert_fails, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // watchdog, scaled to the number of vectors
    initial begin
        wait (cases_loaded);
        #((num_cases + 10) * CLK_PERIOD);
        $display("timeout, the run did not finish within %0d cycles", num_cases + 10);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

//--- xy_route_compute.sv
// XY routing decision as the predicted neighbor router would make it.
// Travels along x first, then along y, and ejects locally on arrival.
// Purely combinational; the result is a one-hot over all five ports.

`timescale 1ns/1ps

module xy_route_compute #(
    parameter int NX = 4,
    parameter int NY = 4
) (
    hop_if.route                        hop,
    output lookahead_pkg::port_onehot_t route_port
);
    import lookahead_pkg::*;

    localparam coord_t LAST_X = coord_t'(NX - 1);
    localparam coord_t LAST_Y = coord_t'(NY - 1);

    coord_t dest_x_in; // destination held inside the mesh
    coord_t dest_y_in;

    // an address past the mesh edge heads for the edge router
    assign dest_x_in = (hop.dest_x > LAST_X) ? LAST_X : hop.dest_x;
    assign dest_y_in = (hop.dest_y > LAST_Y) ? LAST_Y : hop.dest_y;

    always_comb begin
        route_port = '0;
        if (dest_x_in > hop.next_x) begin
            route_port[EAST_PORT] = 1'b1;
        end else if (dest_x_in < hop.next_x) begin
            route_port[WEST_PORT] = 1'b1;
        end else if (dest_y_in < hop.next_y) begin
            route_port[NORTH_PORT] = 1'b1; // north is toward y = 0
        end else if (dest_y_in > hop.next_y) begin
            route_port[SOUTH_PORT] = 1'b1;
        end else begin
            route_port[LOCAL_PORT] = 1'b1; // neighbor is the destination
        end
    end

endmodule
